//--- testbench/div_patterns.hex
// columns: op (0 div, 1 divu, 2 rem, 3 remu), rs1, rs2, expected result
// the all ones line marks the end of the vectors
00000001 00000007 00000002 00000003
00000003 00000007 00000002 00000001
00000001 00000003 00000009 00000000
00000003 00000003 00000009 00000003
00000001 ffffffff 00000001 ffffffff
00000003 ffffffff 00000001 00000000
00000001 ffffffff ffffffff 00000001
00000003 ffffffff ffffffff 00000000
00000001 80000000 00000001 80000000
00000001 80000000 00000010 08000000
00000003 80000000 00000010 00000000
00000001 00000000 00000005 00000000
00000001 00010000 00000003 00005555
00000003 00010000 00000003 00000001
00000001 12345678 00001000 00012345
00000003 12345678 00001000 00000678
00000001 fffffffe 80000000 00000001
00000003 fffffffe 80000000 7ffffffe
00000001 00000064 0000000a 0000000a
00000003 00000064 00000007 00000002
00000000 00000007 00000002 00000003
00000002 00000007 00000002 00000001
00000000 fffffff9 00000002 fffffffd
00000002 fffffff9 00000002 ffffffff
00000000 00000007 fffffffe fffffffd
00000002 00000007 fffffffe 00000001
00000000 fffffff9 fffffffe 00000003
00000002 fffffff9 fffffffe ffffffff
00000000 80000000 00000002 c0000000
00000002 80000000 00000002 00000000
00000000 80000000 00000001 80000000
00000000 7fffffff ffffffff 80000001
00000002 7fffffff ffffffff 00000000
00000000 ffffffff 00000002 00000000
00000002 ffffffff 00000002 ffffffff
00000000 00000005 fffffffd ffffffff
00000002 00000005 fffffffd 00000002
00000000 fffffff6 00000003 fffffffd
00000002 fffffff6 00000003 ffffffff
00000000 12345678 00000000 ffffffff
00000001 12345678 00000000 ffffffff
00000002 12345678 00000000 12345678
00000003 12345678 00000000 12345678
00000000 80000000 00000000 ffffffff
00000002 fffffff9 00000000 fffffff9
00000000 80000000 ffffffff 80000000
00000002 80000000 ffffffff 00000000
00000001 80000000 ffffffff 00000000
00000003 80000000 ffffffff 80000000
ffffffff ffffffff ffffffff ffffffff

//--- flist.f
source/riscv_div_pkg.sv
source/div_cfg_pkg.sv
source/divu_int.sv
source/div_sign_ctrl.sv
source/div_top.sv
testbench/div_asserts.sv
testbench/div_tb.sv

//--- Makefile
TOP := div_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- testbench/div_tb.sv
// divide unit testbench
`timescale 1ns/10ps

module div_tb;
  import riscv_div_pkg::*;
  import div_cfg_pkg::*;

  localparam int MAX_VEC   = 64;   // room in the pattern memory
  localparam int RAND_VECS = 200;
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic            clk_i;
  logic            rst_ni;
  logic            start_i;
  div_op_e         op_i;
  logic [XLEN-1:0] rs1_i;
  logic [XLEN-1:0] rs2_i;
  logic            busy_o;
  logic            done_o;
  logic [XLEN-1:0] result_o;

  logic [XLEN-1:0] pat_mem [0:4*MAX_VEC-1];  // op, rs1, rs2, expected per vector
  int              vec_cnt;
  int              checks      = 0;
  int              errors      = 0;
  int              done_cnt    = 0;           // done pulses seen
  int unsigned     cycle_cnt   = 0;
  int unsigned     cycle_limit = 32'hffff_ffff;  // set once vectors are known
  integer          seed        = 32'h8279_d08a;

  div_top dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .op_i     (op_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .result_o (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////

  // RISC-V M rules, op bit 0 unsigned, bit 1 remainder
  function automatic logic [XLEN-1:0] ref_result(logic [1:0] op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
    logic is_unsigned;
    logic want_rem;
    is_unsigned = op[0];
    want_rem    = op[1];
    if (b == '0) return want_rem ? a : '1;  // divide by zero
    if (!is_unsigned && a == MOST_NEG && b == '1) return want_rem ? '0 : a;  // overflow
    if (is_unsigned) return want_rem ? a % b : a / b;
    return want_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);  // trunc to zero
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // one operation from start pulse to result, plus one idle cycle
  task automatic run_op(input logic [1:0] op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input logic [XLEN-1:0] expected,
                        input string name);
    logic special;
    special = (b == '0) || (!op[0] && a == MOST_NEG && b == '1);
    @(negedge clk_i);
    start_i = 1'b1;
    op_i    = div_op_e'(op);
    rs1_i   = a;
    rs2_i   = b;
    @(negedge clk_i);
    start_i = 1'b0;
    if (special) begin
      check_value({name, " done"}, 1, 32'(done_o));  // answered in one cycle
      check_value({name, " busy"}, 0, 32'(busy_o));
    end else begin
      check_value({name, " busy"}, 1, 32'(busy_o));
      while (done_o !== 1'b1) @(negedge clk_i);    // timeout guards this
      check_value({name, " busy end"}, 0, 32'(busy_o));
    end
    check_value(name, expected, result_o);
    @(negedge clk_i);
    check_value({name, " done pulse"}, 0, 32'(done_o));
    check_value({name, " hold"}, expected, result_o);
  endtask

  // second start during a run must be dropped
  task automatic busy_ignore_check();
    logic [XLEN-1:0] expected;
    int              done_base;
    expected  = ref_result(2'b01, 32'hffff_ffff, 32'd3);
    done_base = done_cnt;
    @(negedge clk_i);
    start_i = 1'b1;
    op_i    = DIV_OP_DIVU;
    rs1_i   = 32'hffff_ffff;
    rs2_i   = 32'd3;
    @(negedge clk_i);
    start_i = 1'b0;
    check_value("ignore busy", 1, 32'(busy_o));
    @(negedge clk_i);
    start_i = 1'b1;               // divide by zero, would end at once if taken
    op_i    = DIV_OP_REM;
    rs1_i   = 32'h0000_1234;
    rs2_i   = '0;
    @(negedge clk_i);
    start_i = 1'b0;
    check_value("ignore no done", 0, 32'(done_o));
    while (done_o !== 1'b1) @(negedge clk_i);
    check_value("ignore result", expected, result_o);
    repeat (XLEN + 6) @(negedge clk_i);  // idle window
    check_value("ignore done count", 1, 32'(done_cnt - done_base));
    check_value("ignore hold", expected, result_o);
  endtask

  ////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && done_o === 1'b1) done_cnt++;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, done_o never arrived", cycle_cnt);
      $display("%0d checks, %0d errors", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_seq
    int              idx;
    logic [1:0]      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              mode;
    rst_ni  = 1'b0;
    start_i = 1'b0;
    op_i    = DIV_OP_DIV;
    rs1_i   = '0;
    rs2_i   = '0;
    for (idx = 0; idx < 4 * MAX_VEC; idx++) pat_mem[idx] = '1;  // end marker fill
    $readmemh("testbench/div_patterns.hex", pat_mem);
    vec_cnt = 0;
    while (vec_cnt < MAX_VEC && pat_mem[4*vec_cnt] != 32'hffff_ffff) vec_cnt++;
    if (vec_cnt == 0) begin
      errors++;
      $display("no vectors could be read from testbench/div_patterns.hex");
    end
    cycle_limit = (vec_cnt + RAND_VECS) * (XLEN + 6) + 20;

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("reset busy", 0, 32'(busy_o));
    check_value("reset done", 0, 32'(done_o));
    check_value("reset result", 0, result_o);

    for (idx = 0; idx < vec_cnt; idx++) begin
      run_op(pat_mem[4*idx][1:0], pat_mem[4*idx+1], pat_mem[4*idx+2], pat_mem[4*idx+3],
             $sformatf("pattern %0d", idx));
    end

    for (idx = 0; idx < RAND_VECS; idx++) begin
      mode = $random(seed) & 7;
      op   = 2'($random(seed));
      a    = $random(seed);
      b    = $random(seed);
      case (mode)
        0: b = '0;                // divide by zero
        1: a = a >> 20;           // small dividend
        2: b = b >> 24;           // small divisor
        3: a = a << 20;           // trailing zeros, early end
        4: begin                  // signed overflow operands
          a = MOST_NEG;
          b = '1;
        end
        default: ;
      endcase
      run_op(op, a, b, ref_result(op, a, b), $sformatf("random %0d", idx));
    end

    busy_ignore_check();

    errors = errors + int'(dut.u_asserts.fail_cnt);  // bound assertion failures
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- testbench/div_asserts.sv
// divide unit control assertions
`timescale 1ns/10ps

module div_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic busy_i,   // top level busy_o
  input logic done_i    // top level done_o
);
  import div_cfg_pkg::*;

  logic [STEP_W-1:0] busy_len;      // cycles busy so far, saturates
  int unsigned       fail_cnt = 0;  // read by the testbench at the end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_len <= '0;
    end else if (!busy_i) begin
      busy_len <= '0;
    end else if (busy_len != '1) begin
      busy_len <= busy_len + STEP_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // control output properties
  ////////////////////////////////////////////////////////////

  done_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o high for more than one cycle");
    end

  no_overlap : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(done_i && busy_i))
    else begin
      fail_cnt++;
      $error("done_o and busy_o high together");
    end

  // busy ends only with the done pulse
  busy_end : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_i) |-> done_i)
    else begin
      fail_cnt++;
      $error("busy_o fell without done_o");
    end

  // done at most XLEN+3 cycles after start, so busy lasts at most XLEN+2
  busy_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_i |-> (busy_len < STEP_W'(XLEN + 2)))
    else begin
      fail_cnt++;
      $error("done_o later than XLEN+3 cycles after start");
    end

endmodule

bind div_top div_asserts u_asserts (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .busy_i (busy_o),
  .done_i (done_o)
);

//--- source/div_top.sv
// integer divide unit top
`timescale 1ns/10ps

module div_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  riscv_div_pkg::div_op_e       op_i,
  input  logic [div_cfg_pkg::XLEN-1:0] rs1_i,
  input  logic [div_cfg_pkg::XLEN-1:0] rs2_i,
  output logic                         busy_o,
  output logic                         done_o,
  output logic [div_cfg_pkg::XLEN-1:0] result_o
);
  import div_cfg_pkg::*;

  ////////////////////////////////////////////////////////////
  // sign control <-> unsigned divider
  ////////////////////////////////////////////////////////////

  logic            div_start;     // pulse
  logic [XLEN-1:0] div_dividend;  // magnitudes
  logic [XLEN-1:0] div_divisor;
  logic            div_busy;
  logic            div_done;      // pulse
  logic [XLEN-1:0] div_quotient;
  logic [XLEN-1:0] div_remainder;

  div_sign_ctrl u_sign_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (start_i),
    .op_i            (op_i),
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .result_o        (result_o),
    .div_start_o     (div_start),
    .div_dividend_o  (div_dividend),
    .div_divisor_o   (div_divisor),
    .div_busy_i      (div_busy),
    .div_done_i      (div_done),
    .div_quotient_i  (div_quotient),
    .div_remainder_i (div_remainder)
  );

  divu_int #(
    .WIDTH (XLEN)
  ) u_divu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (div_start),
    .dividend_i  (div_dividend),
    .divisor_i   (div_divisor),
    .busy_o      (div_busy),
    .done_o      (div_done),
    .quotient_o  (div_quotient),
    .remainder_o (div_remainder)
  );

endmodule

//--- source/div_sign_ctrl.sv
// divide sign and operation control
`timescale 1ns/10ps

module div_sign_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,         // sampled when idle
  input  riscv_div_pkg::div_op_e       op_i,
  input  logic [div_cfg_pkg::XLEN-1:0] rs1_i,           // dividend
  input  logic [div_cfg_pkg::XLEN-1:0] rs2_i,           // divisor
  output logic                         busy_o,
  output logic                         done_o,          // one-cycle pulse
  output logic [div_cfg_pkg::XLEN-1:0] result_o,
  output logic                         div_start_o,     // to divider
  output logic [div_cfg_pkg::XLEN-1:0] div_dividend_o,  // magnitude
  output logic [div_cfg_pkg::XLEN-1:0] div_divisor_o,   // magnitude, non-zero
  input  logic                         div_busy_i,
  input  logic                         div_done_i,
  input  logic [div_cfg_pkg::XLEN-1:0] div_quotient_i,
  input  logic [div_cfg_pkg::XLEN-1:0] div_remainder_i
);
  import riscv_div_pkg::*;
  import div_cfg_pkg::*;

  logic            accept;       // start taken this cycle
  logic            signed_op;
  logic            rem_op;
  logic            rs1_neg;      // negative signed dividend
  logic            rs2_neg;      // negative signed divisor
  logic [XLEN-1:0] rs1_mag;
  logic [XLEN-1:0] rs2_mag;
  logic            div_zero;
  logic            sign_ovf;     // most negative / -1
  logic [XLEN-1:0] special_res;  // result without running the divider

  logic            rem_q;        // return remainder
  logic            neg_quo_q;    // quotient sign
  logic            neg_rem_q;    // remainder sign, follows dividend
  logic [XLEN-1:0] quo_fix;
  logic [XLEN-1:0] rem_fix;

  ////////////////////////////////////////////////////////////
  // decode and operand magnitudes
  ////////////////////////////////////////////////////////////

  always_comb begin
    signed_op = op_is_signed(op_i);
    rem_op    = op_is_rem(op_i);
    rs1_neg   = signed_op & rs1_i[XLEN-1];
    rs2_neg   = signed_op & rs2_i[XLEN-1];
    rs1_mag   = rs1_neg ? -rs1_i : rs1_i;  // abs of most negative stays 2^(XLEN-1)
    rs2_mag   = rs2_neg ? -rs2_i : rs2_i;

    div_zero = (rs2_i == '0);
    sign_ovf = signed_op && (rs1_i == {1'b1, {(XLEN-1){1'b0}}}) && (rs2_i == '1);

    // RISC-V fixed results
    if (div_zero) begin
      special_res = rem_op ? rs1_i : '1;   // x/0 -> all ones, x%0 -> x
    end else begin
      special_res = rem_op ? '0 : rs1_i;   // overflow -> dividend, rem 0
    end
  end

  // divider must be idle too, start into a running divider is lost
  assign accept = start_i & ~busy_o & ~div_busy_i;

  ////////////////////////////////////////////////////////////
  // sign fixup
  ////////////////////////////////////////////////////////////

  always_comb begin
    quo_fix = neg_quo_q ? -div_quotient_i : div_quotient_i;
    rem_fix = neg_rem_q ? -div_remainder_i : div_remainder_i;
  end

  ////////////////////////////////////////////////////////////
  // control and result register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_o      <= 1'b0;
      done_o      <= 1'b0;
      div_start_o <= 1'b0;
      result_o    <= '0;
      rem_q       <= 1'b0;
      neg_quo_q   <= 1'b0;
      neg_rem_q   <= 1'b0;
    end else begin
      done_o      <= 1'b0;  // pulses
      div_start_o <= 1'b0;
      if (accept) begin
        rem_q     <= rem_op;
        neg_quo_q <= rs1_neg ^ rs2_neg;
        neg_rem_q <= rs1_neg;
        if (div_zero || sign_ovf) begin
          // answered directly, busy never rises
          done_o   <= 1'b1;
          result_o <= special_res;
        end else begin
          busy_o      <= 1'b1;
          div_start_o <= 1'b1;
        end
      end else if (busy_o && div_done_i) begin
        busy_o   <= 1'b0;  // falls with done rising
        done_o   <= 1'b1;
        result_o <= rem_q ? rem_fix : quo_fix;
      end
    end
  end

  // operand magnitudes towards the divider
  always_ff @(posedge clk_i) begin
    if (accept) begin
      div_dividend_o <= rs1_mag;
      div_divisor_o  <= rs2_mag;
    end
  end

endmodule

//--- source/divu_int.sv
// iterative unsigned divider
`timescale 1ns/10ps

module divu_int #(
  parameter int WIDTH = div_cfg_pkg::XLEN
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,      // load operands, one cycle
  input  logic [WIDTH-1:0] dividend_i,   // numerator
  input  logic [WIDTH-1:0] divisor_i,    // denominator, never zero
  output logic             busy_o,       // run in progress
  output logic             done_o,       // one-cycle end pulse
  output logic [WIDTH-1:0] quotient_o,   // held after done
  output logic [WIDTH-1:0] remainder_o   // held after done
);
  import div_cfg_pkg::*;

  logic [WIDTH-1:0]  divisor_q;  // copy of divisor
  logic [WIDTH-1:0]  dvd_q;      // dividend bits not yet consumed, msb first
  logic [WIDTH-1:0]  quo_q;      // partial quotient, grows from lsb
  logic [WIDTH-1:0]  acc_q;      // partial remainder, always below divisor
  logic [STEP_W-1:0] cnt_q;      // steps left

  logic [WIDTH:0]    acc_sh;     // remainder with next dividend bit, one bit wider
  logic [WIDTH:0]    acc_diff;   // trial subtraction
  logic              q_bit;      // new quotient bit
  logic [WIDTH-1:0]  acc_next;
  logic [WIDTH-1:0]  quo_next;
  logic              early;      // nothing left to divide

  ////////////////////////////////////////////////////////////
  // one restoring step
  ////////////////////////////////////////////////////////////

  always_comb begin
    acc_sh   = {acc_q, dvd_q[WIDTH-1]};
    acc_diff = acc_sh - {1'b0, divisor_q};
    q_bit    = ~acc_diff[WIDTH];  // no borrow -> divisor fits
    // restore by keeping the shifted value when the subtract underflows
    acc_next = q_bit ? acc_diff[WIDTH-1:0] : acc_sh[WIDTH-1:0];
    quo_next = {quo_q[WIDTH-2:0], q_bit};
  end

  // remaining dividend bits zero and nothing carried in the remainder:
  // every further step would only append a zero quotient bit
  assign early = (dvd_q == '0) && (acc_q == '0);

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_o <= 1'b0;  // pulse
      if (start_i) begin
        busy_o <= 1'b1;
        cnt_q  <= STEP_W'(WIDTH);
      end else if (busy_o) begin
        if (early || cnt_q == STEP_W'(1)) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      divisor_q <= divisor_i;
      dvd_q     <= dividend_i;
      quo_q     <= '0;
      acc_q     <= '0;
    end else if (busy_o) begin
      if (early) begin
        // move partial quotient up by the skipped steps
        quotient_o  <= quo_q << cnt_q;
        remainder_o <= acc_q;
      end else if (cnt_q == STEP_W'(1)) begin
        quotient_o  <= quo_next;  // last bit
        remainder_o <= acc_next;
      end else begin
        dvd_q <= dvd_q << 1;
        quo_q <= quo_next;
        acc_q <= acc_next;
      end
    end
  end

endmodule

//--- source/div_cfg_pkg.sv
// divide unit implementation constants
package div_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // datapath sizing
  ////////////////////////////////////////////////////////////

  // operand and result width, RV32
  localparam int XLEN = 32;

  // iteration counter width
  // must hold the full step count XLEN, hence the extra bit
  localparam int STEP_W = $clog2(XLEN) + 1;

  // one start pulse costs one load cycle, then at most XLEN
  // steps in the divider and one fixup cycle in sign control
  // so done follows start within XLEN+2 cycles

endpackage

//--- source/riscv_div_pkg.sv
// RISC-V divide operation encoding
package riscv_div_pkg;

  ////////////////////////////////////////////////////////////
  // operation codes
  ////////////////////////////////////////////////////////////

  // low two funct3 bits of the M-extension divide group (1xx)
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,  // signed quotient
    DIV_OP_DIVU = 2'b01,  // unsigned quotient
    DIV_OP_REM  = 2'b10,  // signed remainder
    DIV_OP_REMU = 2'b11   // unsigned remainder
  } div_op_e;

  localparam int DIV_OP_UNSIGNED_BIT = 0;  // set for divu / remu
  localparam int DIV_OP_REM_BIT      = 1;  // set for rem / remu

  ////////////////////////////////////////////////////////////
  // decode helpers
  ////////////////////////////////////////////////////////////

  function automatic logic op_is_signed(div_op_e op);
    return ~op[DIV_OP_UNSIGNED_BIT];
  endfunction

  function automatic logic op_is_rem(div_op_e op);
    return op[DIV_OP_REM_BIT];
  endfunction

endpackage
